//--- design/branch_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// Shared types and constants for the branch slice
////////////////////////////////////////////////////////////
package branch_pkg;

  localparam int pc_width = 16;                          // PC, Rs and instruction width

  localparam logic [pc_width-1:0] pc_step  = 16'd2;      // Bytes per instruction
  localparam logic [pc_width-1:0] pc_reset = 16'h0000;   // PC after reset

  // Bit positions inside the 3-bit flag vector
  localparam int flag_z = 2;                             // Zero
  localparam int flag_v = 1;                             // Overflow
  localparam int flag_n = 0;                             // Negative

  // Opcode field, instr[15:12]
  typedef enum logic [3:0] {
    op_add    = 4'd0,                                    // Writes Z, V, N
    op_sub    = 4'd1,                                    // Writes Z, V, N
    op_xor    = 4'd2,                                    // Writes Z only
    op_red    = 4'd3,                                    // No flag update
    op_sll    = 4'd4,                                    // Writes Z only
    op_sra    = 4'd5,                                    // Writes Z only
    op_ror    = 4'd6,                                    // Writes Z only
    op_paddsb = 4'd7,                                    // No flag update
    op_lw     = 4'd8,                                    // Memory and immediate ops
    op_sw     = 4'd9,
    op_llb    = 4'd10,
    op_lhb    = 4'd11,
    op_b      = 4'd12,                                   // PC relative branch
    op_br     = 4'd13,                                   // Branch to Rs
    op_pcs    = 4'd14,
    op_hlt    = 4'd15                                    // Stop the sequencer
  } opcode_e;

  // Condition field, instr[11:9]
  typedef enum logic [2:0] {
    cc_ne     = 3'd0,
    cc_eq     = 3'd1,
    cc_gt     = 3'd2,
    cc_lt     = 3'd3,
    cc_ge     = 3'd4,
    cc_le     = 3'd5,
    cc_ovf    = 3'd6,
    cc_always = 3'd7
  } cond_e;

endpackage

`default_nettype wire

//--- design/cla_16bit.sv
`default_nettype none

// Two level carry lookahead, four 4-bit groups, carry in tied low
module cla_16bit (
  input  logic [15:0] a,
  input  logic [15:0] b,
  output logic [15:0] sum,
  output logic        cout
);

  logic [15:0] g;        // Bit generate
  logic [15:0] p;        // Bit propagate
  logic [15:0] c;        // Carry into each bit
  logic [3:0]  gg;       // Group generate
  logic [3:0]  gp;       // Group propagate
  logic [4:0]  gc;       // Carry into each group, gc[4] is carry out

  assign g = a & b;
  assign p = a ^ b;

  ////////////////////////////////////////////////////////////
  // First level, inside each 4-bit group
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < 4; i++) begin : g_group
    localparam int lsb = 4 * i;

    assign gp[i] = &p[lsb +: 4];
    assign gg[i] = g[lsb+3]
                 | (p[lsb+3] & g[lsb+2])
                 | (p[lsb+3] & p[lsb+2] & g[lsb+1])
                 | (p[lsb+3] & p[lsb+2] & p[lsb+1] & g[lsb]);

    // Local carries from the group carry in
    assign c[lsb]   = gc[i];
    assign c[lsb+1] = g[lsb] | (p[lsb] & gc[i]);
    assign c[lsb+2] = g[lsb+1] | (p[lsb+1] & g[lsb])
                    | (p[lsb+1] & p[lsb] & gc[i]);
    assign c[lsb+3] = g[lsb+2] | (p[lsb+2] & g[lsb+1])
                    | (p[lsb+2] & p[lsb+1] & g[lsb])
                    | (p[lsb+2] & p[lsb+1] & p[lsb] & gc[i]);
  end

  ////////////////////////////////////////////////////////////
  // Second level, across the groups
  ////////////////////////////////////////////////////////////
  assign gc[0] = 1'b0;                                   // Add only, no carry in
  assign gc[1] = gg[0];
  assign gc[2] = gg[1] | (gp[1] & gg[0]);
  assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0]);
  assign gc[4] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
               | (gp[3] & gp[2] & gp[1] & gg[0]);

  assign sum  = p ^ c;
  assign cout = gc[4];

endmodule

`default_nettype wire

//--- design/branch_control.sv
`default_nettype none

// Condition check and target select, purely combinational
module branch_control (
  input  branch_pkg::cond_e                 cond,           // instr[11:9]
  input  logic [8:0]                        offset,         // Word offset, signed
  input  logic [2:0]                        flags,          // Stored Z, V, N
  input  logic [branch_pkg::pc_width-1:0]   rs_data,        // Target for BR
  input  logic                              is_branch,      // B or BR decoded
  input  logic                              is_br,          // BR, target from Rs
  input  logic [branch_pkg::pc_width-1:0]   pc_next,        // PC+2
  output logic                              taken,
  output logic [branch_pkg::pc_width-1:0]   actual_target
);

  import branch_pkg::*;

  logic                zf;                 // Zero flag
  logic                vf;                 // Overflow flag
  logic                nf;                 // Negative flag
  logic                cond_met;           // Condition true, before qualification
  logic [pc_width-1:0] sext_offset;        // Offset widened to PC width
  logic [pc_width-1:0] byte_offset;        // Word offset turned into bytes
  logic [pc_width-1:0] pc_rel_target;      // PC+2 plus offset
  logic [pc_width-1:0] branch_target;      // Target if taken

  assign zf = flags[flag_z];
  assign vf = flags[flag_v];
  assign nf = flags[flag_n];

  ////////////////////////////////////////////////////////////
  // Condition evaluation
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (cond)
      cc_ne:     cond_met = ~zf;
      cc_eq:     cond_met = zf;
      cc_gt:     cond_met = ~zf & ~nf;
      cc_lt:     cond_met = nf;
      cc_ge:     cond_met = zf | (~zf & ~nf);
      cc_le:     cond_met = zf | nf;
      cc_ovf:    cond_met = vf;
      cc_always: cond_met = 1'b1;
      default:   cond_met = 1'b0;               // Unreachable with 3-bit code
    endcase
  end

  assign taken = cond_met & is_branch;          // Only branches can redirect

  ////////////////////////////////////////////////////////////
  // Target computation
  ////////////////////////////////////////////////////////////
  assign sext_offset = {{(pc_width-9){offset[8]}}, offset};
  assign byte_offset = {sext_offset[pc_width-2:0], 1'b0};   // x2

  cla_16bit u_target_add (
    .a    (pc_next),
    .b    (byte_offset),
    .sum  (pc_rel_target),
    .cout ()                                    // Wraps, carry not needed
  );

  assign branch_target = is_br ? rs_data : pc_rel_target;

  // Fall through to PC+2 when the branch is not taken
  assign actual_target = taken ? branch_target : pc_next;

endmodule

`default_nettype wire

//--- design/flag_register.sv
`default_nettype none

// Z, V, N storage with per-opcode write mask
module flag_register (
  input  logic                clk,
  input  logic                reset,
  input  logic                flag_write,      // Instruction accepted this cycle
  input  branch_pkg::opcode_e opcode,
  input  logic [2:0]          alu_flags,       // Flags from the same instruction
  output logic [2:0]          flags
);

  import branch_pkg::*;

  logic [2:0] write_mask;                      // 1 where a flag gets loaded
  logic [2:0] flags_d;

  ////////////////////////////////////////////////////////////
  // Which flags this opcode owns
  ////////////////////////////////////////////////////////////
  always_comb begin
    write_mask = 3'b000;                       // Most opcodes touch nothing
    case (opcode)
      op_add, op_sub: begin
        write_mask[flag_z] = 1'b1;
        write_mask[flag_v] = 1'b1;
        write_mask[flag_n] = 1'b1;
      end
      op_xor, op_sll, op_sra, op_ror: begin
        write_mask[flag_z] = 1'b1;             // Logic and shifts set Z only
      end
      default: begin
        write_mask = 3'b000;                   // RED, PADDSB, branches, memory
      end
    endcase
  end

  // Merge new flags into the kept ones bit by bit
  assign flags_d = (flags & ~write_mask) | (alu_flags & write_mask);

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= 3'b000;
    end else if (flag_write) begin
      flags <= flags_d;                        // Visible to the next instruction
    end
  end

endmodule

`default_nettype wire

//--- design/pc_sequencer.sv
`default_nettype none

// PC register, opcode decode, halt and taken pulse
module pc_sequencer (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              instr_valid,    // One instruction per strobe
  input  branch_pkg::opcode_e               opcode,
  input  logic                              taken,          // From branch_control
  input  logic [branch_pkg::pc_width-1:0]   actual_target,  // Next PC if accepted
  output logic [branch_pkg::pc_width-1:0]   pc,
  output logic [branch_pkg::pc_width-1:0]   pc_next,        // PC+2
  output logic                              is_branch,
  output logic                              is_br,
  output logic                              flag_write,
  output logic                              branch_taken,   // One cycle pulse
  output logic                              halted
);

  import branch_pkg::*;

  logic accept;                                // Instruction consumed at this edge
  logic is_hlt;

  ////////////////////////////////////////////////////////////
  // Sequential PC increment
  ////////////////////////////////////////////////////////////
  cla_16bit u_pc_inc (
    .a    (pc),
    .b    (pc_step),
    .sum  (pc_next),
    .cout ()                                   // PC wraps at the top
  );

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    is_branch = 1'b0;
    is_br     = 1'b0;
    is_hlt    = 1'b0;
    case (opcode)
      op_b:    is_branch = 1'b1;
      op_br: begin
        is_branch = 1'b1;
        is_br     = 1'b1;                      // Target comes from Rs
      end
      op_hlt:  is_hlt = 1'b1;
      default: is_branch = 1'b0;               // Plain sequential instruction
    endcase
  end

  // No back-pressure, a strobe while halted is simply dropped
  assign accept     = instr_valid & ~halted;
  assign flag_write = accept;

  ////////////////////////////////////////////////////////////
  // PC, halt and taken registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      pc           <= pc_reset;
      halted       <= 1'b0;
      branch_taken <= 1'b0;
    end else begin
      branch_taken <= 1'b0;                    // Default low, pulse below
      if (accept) begin
        branch_taken <= taken;
        if (is_hlt) begin
          halted <= 1'b1;                      // Sticky until reset
        end else begin
          pc <= actual_target;                 // PC+2 or the branch target
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/branch_unit_top.sv
`default_nettype none

// Control-flow slice top, instances and field slicing only
module branch_unit_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              instr_valid,
  input  logic [branch_pkg::pc_width-1:0]   instr,
  input  logic [branch_pkg::pc_width-1:0]   rs_data,
  input  logic [2:0]                        alu_flags,
  output logic [branch_pkg::pc_width-1:0]   pc,
  output logic                              branch_taken,
  output logic                              halted
);

  import branch_pkg::*;

  opcode_e             opcode;                 // instr[15:12]
  cond_e               cond;                   // instr[11:9]
  logic [8:0]          offset;                 // instr[8:0]
  logic [pc_width-1:0] pc_next;
  logic [pc_width-1:0] actual_target;
  logic [2:0]          flags;
  logic                is_branch;
  logic                is_br;
  logic                flag_write;
  logic                taken;

  assign opcode = opcode_e'(instr[15:12]);
  assign cond   = cond_e'(instr[11:9]);
  assign offset = instr[8:0];

  pc_sequencer u_pc_sequencer (
    .clk           (clk),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .opcode        (opcode),
    .taken         (taken),
    .actual_target (actual_target),
    .pc            (pc),
    .pc_next       (pc_next),
    .is_branch     (is_branch),
    .is_br         (is_br),
    .flag_write    (flag_write),
    .branch_taken  (branch_taken),
    .halted        (halted)
  );

  flag_register u_flag_register (
    .clk        (clk),
    .reset      (reset),
    .flag_write (flag_write),
    .opcode     (opcode),
    .alu_flags  (alu_flags),
    .flags      (flags)
  );

  branch_control u_branch_control (
    .cond          (cond),
    .offset        (offset),
    .flags         (flags),
    .rs_data       (rs_data),
    .is_branch     (is_branch),
    .is_br         (is_br),
    .pc_next       (pc_next),
    .taken         (taken),
    .actual_target (actual_target)
  );

endmodule

`default_nettype wire

//--- verif/branch_assertions.sv
`default_nettype none

// Checks on the PC sequencer, attached by bind
module branch_assertions (
  input logic                            clk,
  input logic                            reset,
  input logic                            instr_valid,
  input logic                            halted,
  input logic                            branch_taken,
  input logic [branch_pkg::pc_width-1:0] pc
);

  // PC only moves in 2-byte steps and word-scaled offsets
  pc_even: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
    else $error("PC is odd, pc = %h", pc);

  // Halt is sticky until reset
  halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else $error("halted fell without reset");

  // Taken pulse only follows an accepted instruction
  taken_after_accept: assert property (@(posedge clk) disable iff (reset)
    branch_taken |-> $past(instr_valid && !halted))
    else $error("branch_taken without an accepted instruction");

endmodule

bind pc_sequencer branch_assertions u_branch_assertions (
  .clk          (clk),
  .reset        (reset),
  .instr_valid  (instr_valid),
  .halted       (halted),
  .branch_taken (branch_taken),
  .pc           (pc)
);

`default_nettype wire

//--- verif/branch_tb.sv
`default_nettype none

module branch_tb;

  import branch_pkg::*;

  localparam int max_steps    = 64;                   // Room in the pattern memory
  localparam int step_words   = 7;                    // Words per step in the file
  localparam int reset_cycles = 4;
  localparam logic [15:0] end_marker = 16'h000f;      // Valid column value that ends the list

  logic                clk;
  logic                reset;
  logic                instr_valid;
  logic [pc_width-1:0] instr;
  logic [pc_width-1:0] rs_data;
  logic [2:0]          alu_flags;                     // Z, V, N
  logic [pc_width-1:0] pc;
  logic                branch_taken;
  logic                halted;

  logic [15:0] patterns [0:max_steps*step_words-1];   // Stimulus and expected values

  int          step_count  = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;                       // Zero until the patterns are counted

  branch_unit_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .rs_data      (rs_data),
    .alu_flags    (alu_flags),
    .pc           (pc),
    .branch_taken (branch_taken),
    .halted       (halted)
  );

  always #2 clk = ~clk;                               // Period 4

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("TEST FAIL");
      $fatal(1, "watchdog expired");
    end
  end

  // Compare one value with its expected value
  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("Fail at time %0t: %s expected %h got %h", $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Put one step of the file on the DUT inputs
  task automatic drive_step(input int idx);
    int base;
    base        = idx * step_words;
    instr_valid = patterns[base][0];
    instr       = patterns[base+1];
    rs_data     = patterns[base+2];
    alu_flags   = patterns[base+3][2:0];
  endtask

  task automatic check_outputs(input int idx, input logic [15:0] exp_pc,
                               input logic exp_taken, input logic exp_halted);
    check_value($sformatf("pc step %0d", idx), exp_pc, pc);
    check_value($sformatf("branch_taken step %0d", idx), 16'(exp_taken), 16'(branch_taken));
    check_value($sformatf("halted step %0d", idx), 16'(exp_halted), 16'(halted));
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int unsigned idle_count;
    int          base;
    logic [15:0] exp_pc;
    logic        exp_taken;
    logic        exp_halted;

    clk         = 1'b0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    rs_data     = '0;
    alu_flags   = 3'b000;
    void'($urandom(32'hbf85_03ba));                   // Fixed seed for the idle gaps

    $readmemh("verif/branch_patterns.mem", patterns);
    while (step_count < max_steps && patterns[step_count*step_words] != end_marker) begin
      step_count++;
    end
    if (step_count == 0) begin
      $display("The pattern file holds no steps");
      $display("TEST FAIL");
      $fatal(1, "empty pattern file");
    end
    cycle_limit = 5 * step_count + 20;                // At most 4 cycles per step plus reset

    repeat (reset_cycles) @(posedge clk);
    #1 reset = 1'b0;
    check_outputs(0, 16'h0000, 1'b0, 1'b0);           // Values straight out of reset

    for (int i = 0; i < step_count; i++) begin
      base       = i * step_words;
      exp_pc     = patterns[base+4];
      exp_taken  = patterns[base+5][0];
      exp_halted = patterns[base+6][0];
      drive_step(i);
      @(posedge clk);                                 // Accepting edge
      #1;
      check_outputs(i + 1, exp_pc, exp_taken, exp_halted);

      // Idle gap where pc holds and no taken pulse comes
      idle_count  = $urandom % 4;
      instr_valid = 1'b0;
      repeat (idle_count) begin
        @(posedge clk);
        #1;
        check_outputs(i + 1, exp_pc, 1'b0, exp_halted);
      end
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/branch_patterns.mem
// Columns: valid instr rs_data alu_flags(Z V N) | expected pc, branch_taken, halted
// A valid column of f ends the list
1 0000 0000 0 0002 0 0   // ADD, flags all clear
1 1000 0000 4 0004 0 0   // SUB sets Z
1 C204 0000 7 000E 1 0   // B EQ +4 taken, alu flags ignored
1 C004 0000 0 0010 0 0   // B NE not taken
1 0000 0000 1 0012 0 0   // ADD sets N
1 C7FD 0000 0 000E 1 0   // B LT -3 taken, backward
1 C405 0000 0 0010 0 0   // B GT not taken
1 C802 0000 0 0012 0 0   // B GE not taken
1 CA01 0000 0 0016 1 0   // B LE taken
1 1000 0000 0 0018 0 0   // SUB clears all flags
1 C403 0000 0 0020 1 0   // B GT taken
1 C801 0000 0 0024 1 0   // B GE taken
1 CA04 0000 0 0026 0 0   // B LE not taken
1 CC02 0000 0 0028 0 0   // B OVF not taken
1 C001 0000 0 002C 1 0   // B NE taken
1 0000 0000 2 002E 0 0   // ADD sets V
1 CC02 0000 0 0034 1 0   // B OVF taken
1 DE00 0100 0 0100 1 0   // BR always to Rs
1 D200 0200 0 0102 0 0   // BR EQ not taken
1 2000 0000 5 0104 0 0   // XOR loads Z only
1 C608 0000 0 0106 0 0   // B LT not taken, N kept clear
1 C202 0000 0 010C 1 0   // B EQ taken
1 3000 0000 0 010E 0 0   // RED, flags unchanged
1 7000 0000 0 0110 0 0   // PADDSB, flags unchanged
1 CDF8 0000 0 0102 1 0   // B OVF -8 taken, V kept
1 C203 0000 0 010A 1 0   // B EQ taken, Z kept
1 A000 0000 0 010C 0 0   // LLB
1 F000 0000 0 010C 0 1   // HLT
1 0000 0000 3 010C 0 1   // Ignored while halted
1 CE04 0000 0 010C 0 1   // Ignored while halted
F 0000 0000 0 0000 0 0

//--- compile.f
design/branch_pkg.sv
design/cla_16bit.sv
design/branch_control.sv
design/flag_register.sv
design/pc_sequencer.sv
design/branch_unit_top.sv
verif/branch_assertions.sv
verif/branch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the branch unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module branch_tb -o branch_sim \
  || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/branch_sim 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "TEST PASS" && exit 0 || exit 1
